// File: common/lc3b_types.sv
`default_nettype none

package lc3b_types;

  // ==================================================
  // Basic LC-3b data types
  // ==================================================

  typedef logic [15:0] lc3b_word;
  typedef logic [1:0]  lc3b_byte_sel;      // Bit 0 low byte, bit 1 high byte

  // Eight words, word n at bits [16n+15:16n]
  typedef lc3b_word [7:0] lc3b_c_line;

  // ==================================================
  // Word address split for lookup
  // ==================================================

  typedef logic [9:0] lc3b_tag;
  typedef logic [2:0] lc3b_index;          // 8 sets
  typedef logic [2:0] lc3b_offset;         // Word within line

  typedef struct packed {
    lc3b_tag    tag;
    lc3b_index  index;
    lc3b_offset offset;
  } lc3b_addr_fields;

  // Raw view travels on the bus, field view drives the lookup
  typedef union packed {
    lc3b_word        raw;
    lc3b_addr_fields fld;
  } lc3b_addr_u;

endpackage : lc3b_types

`default_nettype wire

// File: common/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

  // ==================================================
  // Wishbone classic, processor side
  // ==================================================

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    lc3b_types::lc3b_byte_sel sel;
    lc3b_types::lc3b_addr_u   adr;
    lc3b_types::lc3b_word     dat;
  } wb_word_req_t;

  typedef struct packed {
    logic                 ack;
    lc3b_types::lc3b_word dat;
  } wb_word_rsp_t;

  // ==================================================
  // Wishbone classic, memory side (whole lines)
  // ==================================================

  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    struct packed {
      lc3b_types::lc3b_tag   tag;
      lc3b_types::lc3b_index index;
    } adr;                                 // Line address
    lc3b_types::lc3b_c_line dat;
  } wb_line_req_t;

  typedef struct packed {
    logic                   ack;
    lc3b_types::lc3b_c_line dat;
  } wb_line_rsp_t;

  // ==================================================
  // Control to datapath
  // ==================================================

  typedef struct packed {
    logic fill;        // Load victim way from memory line
    logic cpu_write;   // Merge processor word into hit line
    logic touch;       // Update LRU for this set
  } dp_cmd_t;

  typedef struct packed {
    logic                   hit;
    logic                   victim_dirty;
    lc3b_types::lc3b_tag    victim_tag;
    lc3b_types::lc3b_word   rdata;
    lc3b_types::lc3b_c_line victim_line;
  } dp_status_t;

  typedef struct packed {
    logic                   hit;
    logic                   valid;
    logic                   dirty;
    lc3b_types::lc3b_tag    tag;
    lc3b_types::lc3b_c_line line;
  } way_status_t;

endpackage : cache_bus_pkg

`default_nettype wire

// File: cache/cache_way.sv
`timescale 1ns/1ns
`default_nettype none

module cache_way (
  input  logic                       clk,
  input  logic                       rst_n,
  input  lc3b_types::lc3b_addr_u     addr,
  input  lc3b_types::lc3b_c_line     line_in,
  input  logic                       write,
  input  logic                       set_dirty,
  output cache_bus_pkg::way_status_t status
);

  import lc3b_types::*;

  // ==================================================
  // Storage, one entry per set
  // ==================================================

  logic [7:0] valid_q;
  logic [7:0] dirty_q;
  lc3b_tag    tag_q  [8];
  lc3b_c_line line_q [8];
  lc3b_index  idx;

  assign idx = addr.fld.index;

  // Valid bit per set
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (write) begin
      valid_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      tag_q[idx]   <= addr.fld.tag;
      dirty_q[idx] <= set_dirty;         // Fill clears, store sets
      line_q[idx]  <= line_in;
    end
  end

  // ==================================================
  // Combinational read and tag compare
  // ==================================================

  always_comb begin
    status.valid = valid_q[idx];
    status.dirty = dirty_q[idx];
    status.tag   = tag_q[idx];
    status.line  = line_q[idx];
    status.hit   = valid_q[idx] && (tag_q[idx] == addr.fld.tag);
  end

endmodule : cache_way

`default_nettype wire

// File: cache/cache_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module cache_datapath (
  input  logic                      clk,
  input  logic                      rst_n,
  input  lc3b_types::lc3b_addr_u    addr,
  input  lc3b_types::lc3b_word      wdata,
  input  lc3b_types::lc3b_byte_sel  sel,
  input  lc3b_types::lc3b_c_line    fill_line,
  input  cache_bus_pkg::dp_cmd_t    cmd,
  output cache_bus_pkg::dp_status_t status
);

  import lc3b_types::*;
  import cache_bus_pkg::*;

  way_status_t way0_st;
  way_status_t way1_st;
  way_status_t hit_st;
  way_status_t victim_st;

  logic [7:0] lru_q;                     // Names the least recently used way
  lc3b_index  idx;
  lc3b_offset off;
  logic       hit_way;
  logic       victim_way;
  lc3b_word   hit_word;
  lc3b_word   merged_word;
  lc3b_c_line way_line_in;
  logic       way0_write;
  logic       way1_write;

  assign idx = addr.fld.index;
  assign off = addr.fld.offset;

  // ==================================================
  // Two ways in parallel
  // ==================================================

  cache_way way0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr      (addr),
    .line_in   (way_line_in),
    .write     (way0_write),
    .set_dirty (cmd.cpu_write),
    .status    (way0_st)
  );

  cache_way way1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr      (addr),
    .line_in   (way_line_in),
    .write     (way1_write),
    .set_dirty (cmd.cpu_write),
    .status    (way1_st)
  );

  // ==================================================
  // Hit, victim and write merge
  // ==================================================

  always_comb begin
    hit_way    = way1_st.hit;            // Way 0 unless way 1 matched
    victim_way = lru_q[idx];
    hit_st     = hit_way ? way1_st : way0_st;
    victim_st  = victim_way ? way1_st : way0_st;
    hit_word   = hit_st.line[off];

    // Byte lane merge of the store word
    merged_word = hit_word;
    if (sel[0]) merged_word[7:0]  = wdata[7:0];
    if (sel[1]) merged_word[15:8] = wdata[15:8];

    if (cmd.fill) begin
      way_line_in = fill_line;
    end else begin
      way_line_in      = hit_st.line;
      way_line_in[off] = merged_word;
    end

    way0_write = (cmd.fill && !victim_way) || (cmd.cpu_write && way0_st.hit && !hit_way);
    way1_write = (cmd.fill && victim_way) || (cmd.cpu_write && way1_st.hit);
  end

  always_comb begin
    status.hit          = way0_st.hit | way1_st.hit;
    status.rdata        = hit_word;
    status.victim_tag   = victim_st.tag;
    status.victim_dirty = victim_st.valid & victim_st.dirty;
    status.victim_line  = victim_st.line;
  end

  // Every access makes the other way least recent
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lru_q <= '0;
    end else if (cmd.touch) begin
      lru_q[idx] <= ~hit_way;
    end
  end

endmodule : cache_datapath

`default_nettype wire

// File: cache/cache_control.sv
`timescale 1ns/1ns
`default_nettype none

module cache_control (
  input  logic                        clk,
  input  logic                        rst_n,
  input  cache_bus_pkg::wb_word_req_t cpu_req,
  output cache_bus_pkg::wb_word_rsp_t cpu_rsp,
  output cache_bus_pkg::wb_line_req_t mem_req,
  input  cache_bus_pkg::wb_line_rsp_t mem_rsp,
  input  cache_bus_pkg::dp_status_t   dp_status,
  output cache_bus_pkg::dp_cmd_t      dp_cmd
);

  typedef enum logic [1:0] {
    IDLE,
    HIT_ACK,
    WRITE_BACK,
    ALLOCATE
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   req_valid;

  assign req_valid = cpu_req.cyc && cpu_req.stb;

  // ==================================================
  // State register
  // ==================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==================================================
  // Next state, datapath command, memory request
  // ==================================================

  always_comb begin
    state_d = state_q;
    dp_cmd  = '0;
    mem_req = '0;

    case (state_q)
      IDLE: begin
        // Lookup happens here, response comes in HIT_ACK
        if (req_valid) begin
          if (dp_status.hit) begin
            dp_cmd.touch     = 1'b1;
            dp_cmd.cpu_write = cpu_req.we;
            state_d          = HIT_ACK;
          end else if (dp_status.victim_dirty) begin
            state_d = WRITE_BACK;
          end else begin
            state_d = ALLOCATE;
          end
        end
      end

      HIT_ACK: begin
        state_d = IDLE;
      end

      WRITE_BACK: begin
        mem_req.cyc       = 1'b1;
        mem_req.stb       = 1'b1;
        mem_req.we        = 1'b1;
        mem_req.adr.tag   = dp_status.victim_tag;     // Victim's own line
        mem_req.adr.index = cpu_req.adr.fld.index;
        mem_req.dat       = dp_status.victim_line;
        if (mem_rsp.ack) begin
          state_d = ALLOCATE;
        end
      end

      ALLOCATE: begin
        mem_req.cyc       = 1'b1;
        mem_req.stb       = 1'b1;
        mem_req.adr.tag   = cpu_req.adr.fld.tag;
        mem_req.adr.index = cpu_req.adr.fld.index;
        if (mem_rsp.ack) begin
          dp_cmd.fill = 1'b1;                         // Memory line lands on this edge
          state_d     = IDLE;                         // Lookup again, now a hit
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ==================================================
  // Processor response
  // ==================================================

  always_comb begin
    cpu_rsp.ack = (state_q == HIT_ACK);
    cpu_rsp.dat = dp_status.rdata;
  end

endmodule : cache_control

`default_nettype wire

// File: source/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  cache_bus_pkg::wb_word_req_t cpu_req,
  output cache_bus_pkg::wb_word_rsp_t cpu_rsp,
  output cache_bus_pkg::wb_line_req_t mem_req,
  input  cache_bus_pkg::wb_line_rsp_t mem_rsp
);

  import cache_bus_pkg::*;

  dp_cmd_t    dp_cmd;
  dp_status_t dp_status;

  // ==================================================
  // Control FSM
  // ==================================================

  cache_control i_control (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .dp_status (dp_status),
    .dp_cmd    (dp_cmd)
  );

  // ==================================================
  // Ways, LRU and merge
  // ==================================================

  cache_datapath i_datapath (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr      (cpu_req.adr),
    .wdata     (cpu_req.dat),
    .sel       (cpu_req.sel),
    .fill_line (mem_rsp.dat),            // Memory read line is the fill data
    .cmd       (dp_cmd),
    .status    (dp_status)
  );

endmodule : cache_top

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 50;       // 100 ns period

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule : tb_clock_gen

`default_nettype wire

// File: verification/cache_sva.sv
`timescale 1ns/1ns
`default_nettype none

module cache_sva (
  input logic                        clk,
  input logic                        rst_n,
  input cache_bus_pkg::wb_word_req_t cpu_req,
  input cache_bus_pkg::wb_word_rsp_t cpu_rsp,
  input cache_bus_pkg::wb_line_req_t mem_req,
  input cache_bus_pkg::wb_line_rsp_t mem_rsp
);

  int fail_count = 0;                    // Assertion failures so far

  // Processor ack only inside an active bus cycle
  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
      cpu_rsp.ack |-> (cpu_req.cyc && cpu_req.stb))
    else begin
      $error("cpu ack seen without cyc and stb");
      fail_count++;
    end

  // Memory request held steady until the memory acks
  a_mem_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
      (mem_req.stb && !mem_rsp.ack) |=> (mem_req.stb && $stable(mem_req.adr)))
    else begin
      $error("memory stb or adr changed before ack");
      fail_count++;
    end

  a_reset_idle: assert property (
    @(posedge clk) !rst_n |=> (!cpu_rsp.ack && !mem_req.cyc))
    else begin
      $error("cpu ack or memory cyc high after reset");
      fail_count++;
    end

endmodule : cache_sva

bind cache_control cache_sva i_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .cpu_req (cpu_req),
  .cpu_rsp (cpu_rsp),
  .mem_req (mem_req),
  .mem_rsp (mem_rsp)
);

`default_nettype wire

// File: verification/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

  import lc3b_types::*;
  import cache_bus_pkg::*;

  localparam int DRIVE_DELAY = 10;
  localparam int ACK_TIMEOUT = 60;       // Enough cycles for a dirty miss with slow memory
  localparam int RANDOM_OPS  = 300;

  typedef logic [12:0] line_addr_t;

  logic         clk;
  logic         rst_n;
  wb_word_req_t cpu_req;
  wb_word_rsp_t cpu_rsp;
  wb_line_req_t mem_req;
  wb_line_rsp_t mem_rsp;

  integer seed;
  int     mem_writes;
  int     wait_cycles;

  lc3b_c_line mem_lines [line_addr_t];   // Lines written back by the cache
  lc3b_word   ref_mem   [lc3b_word];     // Reference image of processor stores
  bit         touched   [lc3b_word];

  // Tag, valid, dirty and LRU model per set
  lc3b_tag    mdl_tag   [8][2];
  logic       mdl_valid [8][2];
  logic       mdl_dirty [8][2];
  logic       mdl_lru   [8];

  string      exp_name_q [$];
  logic       exp_read_q [$];
  lc3b_word   exp_data_q [$];
  logic       exp_hit_q  [$];
  int         exp_wr_q   [$];
  string      cmp_name;
  logic       cmp_read;
  lc3b_word   cmp_data;
  logic       cmp_hit;
  int         cmp_wr;

  tb_clock_gen i_clk_gen (.clk(clk));

  cache_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  // ==================================================
  // Reference and models
  // ==================================================

  function automatic lc3b_word init_word(input lc3b_word addr);
    return {addr[7:0], addr[15:8]} ^ 16'h3C5A;
  endfunction

  function automatic lc3b_word ref_word(input lc3b_word addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return init_word(addr);
  endfunction

  // Word value after the access, stores merged by byte lane
  function automatic lc3b_word ref_access(input lc3b_word addr, input logic we,
                                          input lc3b_byte_sel sel, input lc3b_word wdata);
    lc3b_word word;
    word = ref_word(addr);
    if (we) begin
      if (sel[0]) word[7:0] = wdata[7:0];
      if (sel[1]) word[15:8] = wdata[15:8];
      ref_mem[addr] = word;
    end
    return word;
  endfunction

  // Predicts hit, and on a miss whether the victim goes back to memory
  function automatic logic model_lookup(input lc3b_addr_u a, input logic we,
                                        output logic writeback);
    lc3b_index idx;
    logic      way;
    logic      hit;
    int        w;
    idx       = a.fld.index;
    hit       = 1'b0;
    writeback = 1'b0;
    way       = mdl_lru[idx];
    for (w = 0; w < 2; w++) begin
      if (mdl_valid[idx][w] && (mdl_tag[idx][w] == a.fld.tag)) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      writeback           = mdl_valid[idx][way] && mdl_dirty[idx][way];
      mdl_valid[idx][way] = 1'b1;
      mdl_tag[idx][way]   = a.fld.tag;
      mdl_dirty[idx][way] = 1'b0;      // Fresh fill is clean
    end
    if (we) begin
      mdl_dirty[idx][way] = 1'b1;
    end
    mdl_lru[idx] = ~way;
    return hit;
  endfunction

  function automatic lc3b_c_line read_line(input line_addr_t line);
    lc3b_c_line data;
    int         w;
    if (mem_lines.exists(line)) begin
      return mem_lines[line];
    end
    for (w = 0; w < 8; w++) begin
      data[w] = init_word({line, w[2:0]});
    end
    return data;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // ==================================================
  // Reporting
  // ==================================================

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      report_failure($sformatf("FAIL %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // Protocol assertions bound into the control FSM
  always @(negedge clk) begin
    if (i_dut.i_control.i_sva.fail_count != 0) begin
      report_failure("A Wishbone protocol assertion failed inside the cache");
    end
  end

  // ==================================================
  // Processor master
  // ==================================================

  // Called 10 ns after a rising edge, returns at the same point
  task automatic cpu_access(input string name, input lc3b_word addr, input logic we,
                            input lc3b_byte_sel sel, input lc3b_word wdata);
    lc3b_addr_u a;
    logic       hit;
    logic       wb;
    int         cycles;
    a.raw = addr;
    hit   = model_lookup(a, we, wb);
    exp_name_q.push_back(name);
    exp_read_q.push_back(!we);
    exp_data_q.push_back(ref_access(addr, we, sel, wdata));
    exp_hit_q.push_back(hit);
    exp_wr_q.push_back(mem_writes + int'(wb));
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b1;
    cpu_req.we  = we;
    cpu_req.sel = sel;
    cpu_req.adr = a;
    cpu_req.dat = wdata;
    cycles      = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        report_failure($sformatf("Timeout: no processor ack for %s at address %h", name, addr));
      end
    end while (!cpu_rsp.ack);
    @(posedge clk);
    #DRIVE_DELAY;
    cpu_req = '0;
  endtask

  // Every ack checked against the expectation of its request
  always @(negedge clk) begin
    if (rst_n && cpu_req.cyc && cpu_req.stb) begin
      if (!cpu_rsp.ack) begin
        wait_cycles++;
      end else if (exp_name_q.size() == 0) begin
        report_failure("Processor ack arrived with no request pending");
      end else begin
        cmp_name = exp_name_q.pop_front();
        cmp_read = exp_read_q.pop_front();
        cmp_data = exp_data_q.pop_front();
        cmp_hit  = exp_hit_q.pop_front();
        cmp_wr   = exp_wr_q.pop_front();
        check_equal({cmp_name, " hit in one cycle"}, cmp_hit, wait_cycles == 1);
        if (cmp_read) begin
          check_equal({cmp_name, " read data"}, cmp_data, cpu_rsp.dat);
        end
        check_equal({cmp_name, " memory writes"}, cmp_wr, mem_writes);
        wait_cycles = 0;
      end
    end
  end

  // ==================================================
  // Line memory with random ack delay
  // ==================================================

  initial begin
    logic       busy;
    int         delay;
    line_addr_t line;
    int         w;
    mem_rsp = '0;
    busy    = 1'b0;
    delay   = 0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (mem_rsp.ack) begin
        mem_rsp.ack = 1'b0;
      end else if (rst_n && mem_req.cyc && mem_req.stb) begin
        if (!busy) begin
          busy  = 1'b1;
          delay = rand_below(4);
        end
        if (delay == 0) begin
          line = {mem_req.adr.tag, mem_req.adr.index};
          if (mem_req.we) begin
            for (w = 0; w < 8; w++) begin
              check_equal("victim line word", ref_word({line, w[2:0]}), mem_req.dat[w]);
            end
            mem_lines[line] = mem_req.dat;
            mem_writes++;
          end else begin
            mem_rsp.dat = read_line(line);
          end
          mem_rsp.ack = 1'b1;
          busy        = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================

  initial begin
    int           wr_before;
    int           i;
    int           s;
    lc3b_word     addr;
    logic         we;
    lc3b_byte_sel sel;
    lc3b_word     data;
    seed        = 44636;
    rst_n       = 1'b0;
    cpu_req     = '0;
    mem_writes  = 0;
    wait_cycles = 0;
    for (s = 0; s < 8; s++) begin
      mdl_valid[s][0] = 1'b0;
      mdl_valid[s][1] = 1'b0;
      mdl_lru[s]      = 1'b0;
    end
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    @(negedge clk);
    check_equal("reset cpu ack", 0, cpu_rsp.ack);
    check_equal("reset mem cyc", 0, mem_req.cyc);
    check_equal("reset mem stb", 0, mem_req.stb);
    @(posedge clk);
    #DRIVE_DELAY;
    cpu_access("first read", 16'h0123, 1'b0, 2'b11, 16'h0000);
    cpu_access("read hit", 16'h0123, 1'b0, 2'b11, 16'h0000);
    cpu_access("read hit same line", 16'h0126, 1'b0, 2'b11, 16'h0000);

    // Byte lane stores to a resident line
    wr_before = mem_writes;
    cpu_access("write sel 01", 16'h0123, 1'b1, 2'b01, 16'hA1B2);
    cpu_access("read after sel 01", 16'h0123, 1'b0, 2'b11, 16'h0000);
    cpu_access("write sel 10", 16'h0123, 1'b1, 2'b10, 16'hC3D4);
    cpu_access("read after sel 10", 16'h0123, 1'b0, 2'b11, 16'h0000);
    cpu_access("write sel 11", 16'h0123, 1'b1, 2'b11, 16'hE5F6);
    cpu_access("read after sel 11", 16'h0123, 1'b0, 2'b11, 16'h0000);
    check_equal("resident line writes", wr_before, mem_writes);

    // Three tags on set 5
    wr_before = mem_writes;
    cpu_access("evict read A", {10'h011, 3'd5, 3'd2}, 1'b0, 2'b11, 16'h0000);
    cpu_access("evict write B", {10'h022, 3'd5, 3'd6}, 1'b1, 2'b11, 16'h5A5A);
    cpu_access("evict write A", {10'h011, 3'd5, 3'd2}, 1'b1, 2'b10, 16'h7E00);
    cpu_access("evict read C", {10'h033, 3'd5, 3'd0}, 1'b0, 2'b11, 16'h0000);  // B goes out
    cpu_access("evict read B", {10'h022, 3'd5, 3'd6}, 1'b0, 2'b11, 16'h0000);  // A goes out
    cpu_access("evict read A again", {10'h011, 3'd5, 3'd2}, 1'b0, 2'b11, 16'h0000);
    check_equal("eviction writebacks", wr_before + 2, mem_writes);

    for (i = 0; i < RANDOM_OPS; i++) begin
      addr = lc3b_word'(rand_below(256));    // Four tags per set
      we   = (rand_below(2) != 0);
      sel  = lc3b_byte_sel'(rand_below(3) + 1);
      data = lc3b_word'($random(seed));
      touched[addr] = 1'b1;
      cpu_access("random mix", addr, we, sel, data);
    end
    foreach (touched[a]) begin
      cpu_access("read back", a, 1'b0, 2'b11, 16'h0000);
    end

    if (i_dut.i_control.i_sva.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_failure("A Wishbone protocol assertion failed inside the cache");
    end
  end

endmodule : cache_tb

`default_nettype wire

// File: project.f
common/lc3b_types.sv
common/cache_bus_pkg.sv
cache/cache_way.sv
cache/cache_datapath.sv
cache/cache_control.sv
source/cache_top.sv
verification/tb_clock_gen.sv
verification/cache_sva.sv
verification/cache_tb.sv

// File: Bender.yml
package:
  name: lc3b_cache

sources:
  # Shared packages
  - common/lc3b_types.sv
  - common/cache_bus_pkg.sv

  # Cache RTL
  - cache/cache_way.sv
  - cache/cache_datapath.sv
  - cache/cache_control.sv
  - source/cache_top.sv

  # Testbench, assertions and clock
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/cache_sva.sv
      - verification/cache_tb.sv
